// File: include/rom_defines.svh
/*
 * width macros for the ROM loading subsystem
 * byte width, full memory address width, checksum width
 */

`ifndef ROM_DEFINES_SVH
`define ROM_DEFINES_SVH

// one ROM byte as it arrives from the download stream
`define ROM_DW 8

// full program memory address, 1 KiB of ROM
// the top bit splits the space between cpu and gfx halves
`define ROM_AW 10

// running byte sum kept by the loader, wraps modulo 2^16
`define ROM_SUMW 16

`endif

// File: hdl/rom_pkg.sv
/*
 * shared types for the ROM subsystem
 * width typedefs, read request/response structs, write struct
 * and the arbiter state enum
 */

`include "rom_defines.svh"

package rom_pkg;

    typedef logic [`ROM_DW-1:0]   rom_data_t;  // one ROM byte
    typedef logic [`ROM_AW-1:0]   rom_addr_t;  // full memory address
    typedef logic [`ROM_AW-2:0]   port_addr_t; // address inside one port's half
    typedef logic [`ROM_SUMW-1:0] rom_sum_t;   // byte checksum, mod 2^16

    // fetch port -> arbiter
    typedef struct packed {
        logic      pending; // level, held until the cycle after ok
        rom_addr_t addr;    // region bit already on top
    } rd_req_t;

    // arbiter -> fetch port
    typedef struct packed {
        logic      ok;   // one-cycle pulse
        rom_data_t data; // valid with ok
    } rd_rsp_t;

    // loader -> memory write side
    typedef struct packed {
        logic      we;
        rom_addr_t addr;
        rom_data_t data;
    } prom_wr_t;

    typedef enum logic {ARB_IDLE, ARB_READ} arb_state_t;

endpackage

// File: hdl/rom_prom.sv
/*
 * program memory with independent write and read addresses
 * write side is free running, read register updates on cen
 */

`timescale 1ns/1ns

`include "rom_defines.svh"

module rom_prom #(
    parameter int dw = `ROM_DW,
    parameter int aw = `ROM_AW
) (
    input  logic               clk,
    input  logic               cen,     // read enable from the arbiter
    input  rom_pkg::prom_wr_t  wr,      // write from the loader
    input  rom_pkg::rom_addr_t rd_addr,
    output rom_pkg::rom_data_t q
);

    import rom_pkg::*;

    logic [dw-1:0] mem [0:(2**aw)-1]; // the ROM image, no reset

    logic [aw-1:0] wa;   // write index
    logic [aw-1:0] ra;   // read index
    logic [dw-1:0] wd;   // write byte

    // narrow the package-wide fields down to this instance's geometry
    assign wa = wr.addr[aw-1:0];
    assign ra = rd_addr[aw-1:0];
    assign wd = wr.data[dw-1:0];

    // write side has no enable so the download runs at full rate
    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wa] <= wd;
        end
    end

    // registered read, data valid one cycle after an enabled edge
    // a write lands on edge n and is seen by a read on edge n+1
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= rom_data_t'(mem[ra]); // zero extend if dw is narrow
        end
    end

    // the loader must present a clean address with every strobe
    a_wr_addr_known : assert property (
        @(posedge clk) wr.we |-> !$isunknown(wr.addr)
    ) else $error("prom write with unknown address");

endmodule

// File: hdl/rom_loader.sv
/*
 * download stream to memory write converter
 * drops out-of-range addresses, keeps the byte checksum,
 * the loading level and the sticky rom_ready level
 */

`timescale 1ns/1ns

`include "rom_defines.svh"

module rom_loader (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               dl_active, // high for the whole download
    input  logic               dl_wr,     // one-cycle byte strobe
    input  logic [15:0]        dl_addr,
    input  rom_pkg::rom_data_t dl_data,
    output rom_pkg::prom_wr_t  wr,
    output logic               loading,
    output logic               rom_ready,
    output rom_pkg::rom_sum_t  checksum
);

    import rom_pkg::*;

    logic      accept;   // strobe that lands inside the memory
    logic      dl_fall;  // end of download seen this cycle
    logic      wr_we;
    rom_addr_t wr_addr;
    rom_data_t wr_data;

    // anything at or above 2^ROM_AW is silently dropped
    assign accept  = dl_wr && (dl_addr[15:`ROM_AW] == '0);
    assign dl_fall = loading && !dl_active; // loading is the delayed copy

    // control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_we     <= 1'b0;
            loading   <= 1'b0;
            rom_ready <= 1'b0;
            checksum  <= '0;
        end else begin
            wr_we   <= accept;    // write issued the cycle after dl_wr
            loading <= dl_active;
            if (accept) begin
                // sum moves in step with the write strobe
                checksum <= checksum + rom_sum_t'(dl_data);
            end
            if (dl_fall) begin
                rom_ready <= 1'b1; // sticky until reset
            end
        end
    end

    // write payload, only meaningful with wr_we
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_addr <= dl_addr[`ROM_AW-1:0];
            wr_data <= dl_data;
        end
    end

    assign wr = '{we: wr_we, addr: wr_addr, data: wr_data};

    // host protocol: bytes only arrive inside a download window
    a_wr_in_window : assert property (
        @(posedge clk) disable iff (!rst_n)
        dl_wr |-> dl_active
    ) else $error("dl_wr outside of dl_active");

endmodule

// File: hdl/rom_arbiter.sv
/*
 * round-robin arbiter for the memory read port
 * two fetch ports, cpu and gfx, two-cycle grant,
 * no new grant while the loader is active
 */

`timescale 1ns/1ns

module rom_arbiter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               loading,  // blocks new grants
    input  rom_pkg::rd_req_t   cpu_req,
    input  rom_pkg::rd_req_t   gfx_req,
    output rom_pkg::rd_rsp_t   cpu_rsp,
    output rom_pkg::rd_rsp_t   gfx_rsp,
    output rom_pkg::rom_addr_t rd_addr,
    output logic               cen,      // memory read enable
    input  rom_pkg::rom_data_t q
);

    import rom_pkg::*;

    arb_state_t state;
    logic       last_gfx;  // gfx was served last, cpu wins the next tie
    logic       sel_gfx;   // winner of the grant in flight
    logic       any_req;
    logic       pick_gfx;  // winner if a grant starts now
    logic       start;     // grant starts this cycle

    assign any_req = cpu_req.pending || gfx_req.pending;

    // gfx wins alone, or on a tie when cpu had the last turn
    always_comb begin
        if (gfx_req.pending && cpu_req.pending) begin
            pick_gfx = !last_gfx;
        end else begin
            pick_gfx = gfx_req.pending;
        end
    end

    assign start = (state == ARB_IDLE) && any_req && !loading;

    // read address and enable go out in the idle cycle
    assign cen     = start;
    assign rd_addr = pick_gfx ? gfx_req.addr : cpu_req.addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ARB_IDLE;
            last_gfx <= 1'b1;   // first tie goes to the cpu
            sel_gfx  <= 1'b0;
        end else begin
            unique case (state)
                ARB_IDLE: begin
                    if (start) begin
                        state    <= ARB_READ;
                        sel_gfx  <= pick_gfx;
                        last_gfx <= pick_gfx; // rotate priority
                    end
                end
                ARB_READ: begin
                    state <= ARB_IDLE; // memory q is valid now, ok goes out
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    // memory output routed to whoever holds the grant
    always_comb begin
        cpu_rsp.ok   = (state == ARB_READ) && !sel_gfx;
        cpu_rsp.data = q;
        gfx_rsp.ok   = (state == ARB_READ) && sel_gfx;
        gfx_rsp.data = q;
    end

    // a response only goes to a port that still waits for it
    a_ok_to_pending : assert property (
        @(posedge clk) disable iff (!rst_n)
        (cpu_rsp.ok || gfx_rsp.ok) |-> (cpu_rsp.ok ? cpu_req.pending : gfx_req.pending)
    ) else $error("ok pulse sent to a port with no pending read");

endmodule

// File: hdl/rom_fetch_port.sv
/*
 * fetch port into one half of the program memory
 * latches a read strobe, holds the request until served,
 * returns held data with a one-cycle rd_ok
 */

`timescale 1ns/1ns

module rom_fetch_port #(
    parameter int region = 0  // top address bit for this port
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rd,      // one-cycle read strobe
    input  rom_pkg::port_addr_t addr,    // address inside this half
    output rom_pkg::rd_req_t    req,
    input  rom_pkg::rd_rsp_t    rsp,
    output rom_pkg::rom_data_t  rd_data,
    output logic                rd_ok
);

    import rom_pkg::*;

    localparam bit region_bit = (region != 0);

    logic      pending;
    rom_addr_t req_addr;

    // pending rises the cycle after rd and drops the cycle after ok
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
            rd_ok   <= 1'b0;
        end else begin
            rd_ok <= rsp.ok;    // one-cycle pulse, data lands with it
            if (rsp.ok) begin
                pending <= 1'b0;
            end
            if (rd) begin
                pending <= 1'b1;
            end
        end
    end

    // address and data holding registers
    always_ff @(posedge clk) begin
        if (rd) begin
            req_addr <= {region_bit, addr}; // select this port's half
        end
        if (rsp.ok) begin
            rd_data <= rsp.data; // held until the next read completes
        end
    end

    assign req = '{pending: pending, addr: req_addr};

    // one outstanding read per port, a second strobe would be lost
    a_no_rd_while_pending : assert property (
        @(posedge clk) disable iff (!rst_n)
        rd |-> !pending
    ) else $error("rd strobe while a read is pending");

endmodule

// File: hdl/rom_sys_top.sv
/*
 * ROM subsystem top
 * loader, program memory, read arbiter, cpu and gfx fetch ports
 */

`timescale 1ns/1ns

`include "rom_defines.svh"

module rom_sys_top (
    input  logic                clk,
    input  logic                rst_n,
    // download stream
    input  logic                dl_active,
    input  logic                dl_wr,
    input  logic [15:0]         dl_addr,
    input  rom_pkg::rom_data_t  dl_data,
    // cpu fetch, lower half
    input  logic                cpu_rd,
    input  rom_pkg::port_addr_t cpu_addr,
    output rom_pkg::rom_data_t  cpu_data,
    output logic                cpu_ok,
    // gfx fetch, upper half
    input  logic                gfx_rd,
    input  rom_pkg::port_addr_t gfx_addr,
    output rom_pkg::rom_data_t  gfx_data,
    output logic                gfx_ok,
    // status for the host
    output logic                rom_ready,
    output rom_pkg::rom_sum_t   checksum
);

    rom_pkg::prom_wr_t  prom_wr;  // loader -> memory
    logic               loading;
    logic               cen;      // arbiter -> memory read enable
    rom_pkg::rom_addr_t rd_addr;
    rom_pkg::rom_data_t q;
    rom_pkg::rd_req_t   cpu_req, gfx_req;
    rom_pkg::rd_rsp_t   cpu_rsp, gfx_rsp;

    rom_loader u_loader (
        .clk(clk), .rst_n(rst_n),
        .dl_active(dl_active), .dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data),
        .wr(prom_wr), .loading(loading), .rom_ready(rom_ready), .checksum(checksum)
    );

    rom_prom #(.dw(`ROM_DW), .aw(`ROM_AW)) u_prom (
        .clk(clk), .cen(cen), .wr(prom_wr), .rd_addr(rd_addr), .q(q)
    );

    rom_arbiter u_arbiter (
        .clk(clk), .rst_n(rst_n), .loading(loading),
        .cpu_req(cpu_req), .gfx_req(gfx_req), .cpu_rsp(cpu_rsp), .gfx_rsp(gfx_rsp),
        .rd_addr(rd_addr), .cen(cen), .q(q)
    );

    rom_fetch_port #(.region(0)) u_cpu_port (   // lower half
        .clk(clk), .rst_n(rst_n), .rd(cpu_rd), .addr(cpu_addr),
        .req(cpu_req), .rsp(cpu_rsp), .rd_data(cpu_data), .rd_ok(cpu_ok)
    );

    rom_fetch_port #(.region(1)) u_gfx_port (   // upper half
        .clk(clk), .rst_n(rst_n), .rd(gfx_rd), .addr(gfx_addr),
        .req(gfx_req), .rsp(gfx_rsp), .rd_data(gfx_data), .rd_ok(gfx_ok)
    );

endmodule

// File: testbench/rom_sys_tb.sv
/*
 * testbench for the ROM subsystem top
 * clock and reset, stim file interpreter, reference memory and checksum,
 * checks on read data, checksum and ready, per-test report and counts
 */

`timescale 1ns/1ns

`include "rom_defines.svh"

module rom_sys_tb;

    import rom_pkg::*;

    localparam int          timeout_cycles = 50;
    localparam int          mem_words      = 1 << `ROM_AW;
    localparam logic [15:0] mem_limit      = 16'(1 << `ROM_AW); // first dropped address

    logic       clk = 1'b0;
    logic       rst_n;
    logic       dl_active;
    logic       dl_wr;
    logic [15:0] dl_addr;
    rom_data_t  dl_data;
    logic       cpu_rd, gfx_rd;
    port_addr_t cpu_addr, gfx_addr;
    rom_data_t  cpu_data, gfx_data;
    logic       cpu_ok, gfx_ok;
    logic       rom_ready;
    rom_sum_t   checksum;

    rom_data_t  ref_mem [0:mem_words-1]; // what the memory should hold
    rom_sum_t   ref_sum;                 // sum of accepted bytes
    logic       out_valid [0:1];         // read in flight, 0 cpu 1 gfx
    port_addr_t out_addr  [0:1];
    rom_data_t  out_exp   [0:1];         // expected byte from the stim line
    int         n_tests, n_fail, n_errs;

    always #5 clk = ~clk; // 10 ns period

    rom_sys_top rom_sys_top_i (
        .clk(clk), .rst_n(rst_n),
        .dl_active(dl_active), .dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data),
        .cpu_rd(cpu_rd), .cpu_addr(cpu_addr), .cpu_data(cpu_data), .cpu_ok(cpu_ok),
        .gfx_rd(gfx_rd), .gfx_addr(gfx_addr), .gfx_data(gfx_data), .gfx_ok(gfx_ok),
        .rom_ready(rom_ready), .checksum(checksum)
    );

    // one result line per test, error line first on a mismatch
    task automatic finish_test(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        logic good;
        good = (act == exp);
        n_tests++;
        assert (good) else begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            n_fail++;
        end
        $display("test %-22s %s", name, good ? "ok" : "failed");
    endtask

    // stim expectation must agree with the reference model
    task automatic model_check(input string name, input logic [15:0] model,
                               input logic [15:0] file_exp);
        assert (model == file_exp) else begin
            $display("reference model holds %h for %s but the stim file expects %h",
                     model, name, file_exp);
            n_errs++;
        end
    endtask

    task automatic drive_load(input logic [15:0] addr, input rom_data_t data);
        @(negedge clk);
        dl_active = 1'b1;   // first strobe opens the download window
        dl_wr     = 1'b1;
        dl_addr   = addr;
        dl_data   = data;
        @(negedge clk);
        dl_wr = 1'b0;
        if (addr < mem_limit) begin // out-of-range bytes leave no trace
            ref_mem[addr[`ROM_AW-1:0]] = data;
            ref_sum = ref_sum + rom_sum_t'(data);
        end
    endtask

    task automatic start_read(input logic port, input port_addr_t addr, input rom_data_t exp);
        if (port) begin
            gfx_rd   = 1'b1;
            gfx_addr = addr;
        end else begin
            cpu_rd   = 1'b1;
            cpu_addr = addr;
        end
        out_valid[port] = 1'b1;
        out_addr[port]  = addr;
        out_exp[port]   = exp;
    endtask

    task automatic check_read(input logic port, input rom_data_t act);
        string     name;
        rom_addr_t full;
        name = $sformatf("%s_rd_%03h", port ? "gfx" : "cpu", out_addr[port]);
        full = {port, out_addr[port]}; // gfx lives in the upper half
        model_check(name, 16'(ref_mem[full]), 16'(out_exp[port]));
        finish_test(name, 16'(out_exp[port]), 16'(act));
        out_valid[port] = 1'b0;
    endtask

    // wait for every read in flight, sampled mid-cycle
    task automatic collect_reads();
        int cycles;
        cycles = 0;
        while ((out_valid[0] || out_valid[1]) && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
            if (out_valid[0] && cpu_ok) check_read(1'b0, cpu_data);
            if (out_valid[1] && gfx_ok) check_read(1'b1, gfx_data);
        end
        if (out_valid[0] || out_valid[1]) begin
            $display("timeout, a read got no rd_ok within %0d cycles", timeout_cycles);
            n_fail++;
            out_valid[0] = 1'b0;
            out_valid[1] = 1'b0;
        end
    endtask

    task automatic end_download();
        int cycles;
        finish_test("ready_low_in_download", 16'h0, 16'(rom_ready));
        @(negedge clk);
        dl_active = 1'b0;
        cycles = 0;
        while (!rom_ready && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (!rom_ready) begin
            $display("timeout, rom_ready stayed low after the download ended");
            n_fail++;
        end else begin
            // ready follows one rising edge after dl_active drops
            finish_test("ready_delay_cycles", 16'd1, 16'(cycles));
        end
        collect_reads(); // reads held back by the download finish now
    endtask

    // ok pulses never overlap and never arrive during a download
    always @(negedge clk) begin
        if (rst_n) begin
            assert (!(cpu_ok && gfx_ok)) else begin
                $display("cpu and gfx rd_ok were high in the same cycle");
                n_errs++;
            end
            if (cpu_ok || gfx_ok) begin
                assert (rom_ready) else begin
                    $display("rd_ok arrived while the download was still running");
                    n_errs++;
                end
            end
        end
    end

    initial begin
        int          fd;
        int          code;
        int          i;
        string       line;
        string       rest;
        logic [7:0]  cmd;
        logic [31:0] p0, a0, e0, p1, a1, e1;
        rst_n = 1'b0;
        dl_active = 1'b0;
        dl_wr = 1'b0;
        dl_addr = '0;
        dl_data = '0;
        cpu_rd = 1'b0;
        cpu_addr = '0;
        gfx_rd = 1'b0;
        gfx_addr = '0;
        n_tests = 0;
        n_fail = 0;
        n_errs = 0;
        ref_sum = '0;
        for (i = 0; i < mem_words; i++) ref_mem[i] = '0;
        out_valid[0] = 1'b0;
        out_valid[1] = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;             // two rising edges in reset
        fd = $fopen("testbench/rom_sys_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/rom_sys_stim.txt");
            n_fail++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 0) begin
                    cmd  = line.getc(0);
                    rest = line.substr(1, line.len() - 1);
                    case (cmd)
                        "L": begin
                            code = $sscanf(rest, "%h %h", a0, e0);
                            drive_load(a0[15:0], e0[7:0]);
                        end
                        "E": end_download();
                        "R": begin
                            code = $sscanf(rest, "%d %h %h %d %h %h", p0, a0, e0, p1, a1, e1);
                            @(negedge clk);
                            start_read(p0[0], a0[`ROM_AW-2:0], e0[7:0]);
                            if (code == 6) start_read(p1[0], a1[`ROM_AW-2:0], e1[7:0]);
                            @(negedge clk);
                            cpu_rd = 1'b0;
                            gfx_rd = 1'b0;
                            if (!dl_active) collect_reads(); // else held until E
                        end
                        "C": begin
                            code = $sscanf(rest, "%h", e0);
                            @(negedge clk);
                            model_check("checksum", 16'(ref_sum), e0[15:0]);
                            finish_test("checksum", e0[15:0], 16'(checksum));
                        end
                        default: ; // comments and blank lines
                    endcase
                end
            end
            $fclose(fd);
        end
        $display("tests %0d, failed %0d, other errors %0d", n_tests, n_fail, n_errs);
        if (n_fail == 0 && n_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/rom_sys_stim.txt
# L dl_addr(hex) byte(hex) | E | C checksum(hex)
# R port(0 cpu, 1 gfx) port_addr(hex) expected(hex) [port port_addr expected]
L 000 11
L 001 22
L 002 33
L 003 44
L 010 5a
L 07f c3
L 1ff 0f
L 200 a1
L 201 b2
L 202 c4
L 203 d8
L 210 e7
L 27f 96
L 3ff f0
# read issued inside the download, byte arrives later
R 0 005 77
L 005 77
# out of range, would alias 000, 200 and 3ff if kept
L 0400 ee
L 0600 ee
L 07ff 99
L ffff 55
E
C 07a9
# cpu port, lower half
R 0 000 11
R 0 001 22
R 0 003 44
R 0 010 5a
R 0 07f c3
R 0 1ff 0f
# gfx port, upper half at the same port addresses
R 1 000 a1
R 1 001 b2
R 1 010 e7
R 1 07f 96
R 1 1ff f0
# both ports in the same cycle
R 0 002 33 1 002 c4
R 0 003 44 1 003 d8
R 0 000 11 1 000 a1
R 0 005 77 1 010 e7
C 07a9

// File: project.f
+incdir+include
hdl/rom_pkg.sv
hdl/rom_prom.sv
hdl/rom_loader.sv
hdl/rom_arbiter.sv
hdl/rom_fetch_port.sv
hdl/rom_sys_top.sv
testbench/rom_sys_tb.sv

// File: Makefile
# Verilator build and run of the ROM subsystem testbench

VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0 --timescale 1ns/1ns
TOP       := rom_sys_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
